// File: project.f
+incdir+.
noc_flit_pkg.sv
noc_arb_pkg.sv
flit_fifo.sv
output_arbiter.sv
router_output.sv
router_output_asserts.sv
tb_router_output.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_router_output
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log

SOURCES   = $(wildcard *.sv *.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_router_output.sv
`include "noc_config.svh"

module tb_router_output;
  import noc_flit_pkg::*;

  localparam int NUM = `NOC_NUM_PORTS;
  localparam int DEPTH = `NOC_FIFO_DEPTH;
  localparam int SRC_LSB = `NOC_FLIT_WIDTH - 3; // Source port sits in the top 3 bits
  localparam int STIM_CYCLES = 2000;
  localparam int DRAIN_CYCLES = 1000;
  localparam int WATCHDOG_CYCLES = 2 * (STIM_CYCLES + DRAIN_CYCLES);

  logic               clk;
  logic               rst;
  logic               dcts;
  logic [NUM-1:0]     wr_vec;
  flit_t              data_arr [NUM];
  wire  [NUM-1:0]     full_vec;
  logic               rts;
  flit_t              tx_data;

  logic [31:0]        lfsr_state;
  logic [SRC_LSB-1:0] seq [NUM];
  flit_t              model_q [NUM][$]; // One queue per source
  int                 occ [NUM];
  int                 expect_src;       // NUM while the arbiter is idle
  logic               rts_low_next;
  int                 delivered;
  int                 errors;
  string              port_letters = "newsl";

  router_output DUT (
    .clk(clk), .rst(rst), .dcts(dcts),
    .wr_n(wr_vec[0]), .wr_e(wr_vec[1]), .wr_w(wr_vec[2]), .wr_s(wr_vec[3]), .wr_l(wr_vec[4]),
    .data_n(data_arr[0]), .data_e(data_arr[1]), .data_w(data_arr[2]),
    .data_s(data_arr[3]), .data_l(data_arr[4]),
    .full_n(full_vec[0]), .full_e(full_vec[1]), .full_w(full_vec[2]),
    .full_s(full_vec[3]), .full_l(full_vec[4]),
    .rts(rts), .tx_data(tx_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Rotating priority, the current port is checked first
  function automatic int next_source(input int cur, input port_sel_t lvl);
    int p;
    for (int k = 0; k < NUM; k++) begin
      p = (cur + k) % NUM;
      if (lvl[p])
        return p;
    end
    return NUM; // No request, arbiter drops to idle
  endfunction

  task automatic fail_run(input string why);
    errors++;
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_flit(input string name, input flit_t got, input flit_t exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp));
  endtask

  task automatic check_sel(input string name, input port_sel_t got, input port_sel_t exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp));
  endtask

  task automatic drive_inputs(input logic writes_on);
    for (int i = 0; i < NUM; i++) begin
      if (writes_on && take_bits(4) < 5) begin // About 30 percent
        wr_vec[i]   <= 1'b1;
        data_arr[i] <= {3'(i), seq[i]};
        seq[i] = seq[i] + 1'b1;
      end else begin
        wr_vec[i] <= 1'b0;
      end
    end
    if (writes_on)
      dcts <= (take_bits(4) < 10); // About 60 percent
    else
      dcts <= 1'b1;
  endtask

  // Runs at the falling edge, checks outputs and predicts the coming edge
  task automatic check_cycle();
    logic [NUM-1:0] accept;
    port_sel_t      req_lvl;
    flit_t          exp_flit;
    int             src;
    logic           xfer;
    for (int i = 0; i < NUM; i++) begin
      check_level($sformatf("full_%s", port_letters.substr(i, i)), full_vec[i], occ[i] == DEPTH);
      accept[i] = wr_vec[i] && (occ[i] != DEPTH);
    end
    if (rts_low_next)
      check_level("rts", rts, 1'b0);
    xfer = rts && dcts;
    if (xfer) begin
      src = int'(tx_data[`NOC_FLIT_WIDTH-1:SRC_LSB]);
      if (src >= NUM || occ[src] == 0)
        fail_run($sformatf("Transfer at %0t from source %0d, which holds no flit", $time, src));
      check_sel("source", port_sel_t'(1) << src, port_sel_t'(1) << expect_src);
      exp_flit = model_q[src].pop_front();
      check_flit("tx_data", tx_data, exp_flit);
      occ[src]--;
      delivered++;
      for (int i = 0; i < NUM; i++)
        req_lvl[i] = (occ[i] > 0); // Popped source already reduced
      expect_src = next_source(src, req_lvl);
    end else if (expect_src == NUM) begin
      for (int i = 0; i < NUM; i++)
        req_lvl[i] = (occ[i] > 0);
      expect_src = next_source(NUM - 1, req_lvl); // Idle searches from Local
    end
    for (int i = 0; i < NUM; i++) begin
      if (accept[i]) begin
        model_q[i].push_back(data_arr[i]);
        occ[i]++;
      end
    end
    rts_low_next = xfer;
  endtask

  function automatic int occ_total();
    int sum;
    sum = 0;
    for (int i = 0; i < NUM; i++)
      sum += occ[i];
    return sum;
  endfunction

  initial begin
    rst = 1'b1;
    dcts = 1'b0;
    wr_vec = '0;
    lfsr_state = 32'h34f3;
    expect_src = NUM;
    rts_low_next = 1'b0;
    delivered = 0;
    errors = 0;
    for (int i = 0; i < NUM; i++) begin
      data_arr[i] = '0;
      seq[i] = '0;
      occ[i] = 0;
    end
    for (int c = 0; c < 5; c++) begin
      @(posedge clk);
      if (c == 4)
        rst <= 1'b0;
      @(negedge clk);
      check_level("rts", rts, 1'b0);
    end
    rts_low_next = 1'b1; // First cycle out of reset
    for (int c = 0; c < STIM_CYCLES; c++) begin
      @(posedge clk);
      drive_inputs(1'b1);
      @(negedge clk);
      check_cycle();
    end
    while (occ_total() != 0 || rts) begin
      @(posedge clk);
      drive_inputs(1'b0);
      @(negedge clk);
      check_cycle();
    end
    repeat (4) begin
      @(posedge clk);
      drive_inputs(1'b0);
      @(negedge clk);
      check_cycle();
      check_level("rts", rts, 1'b0);
    end
    $display("%0d flits delivered", delivered);
    if (delivered == 0)
      fail_run("No flit was delivered on the output link");
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, the buffers never drained", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule

// File: router_output_asserts.sv
module router_output_asserts (
  input logic                    clk,
  input logic                    rst,
  input logic                    dcts,
  input logic                    rts,
  input logic                    req_n, req_e, req_w, req_s, req_l,
  input logic                    grant_n, grant_e, grant_w, grant_s, grant_l,
  input noc_flit_pkg::flit_t     tx_data,
  input noc_arb_pkg::arb_state_t state
);
  import noc_flit_pkg::*;
  import noc_arb_pkg::*;

  port_sel_t req_vec;
  port_sel_t grant_vec;

  assign req_vec   = {req_l, req_s, req_w, req_e, req_n};
  assign grant_vec = {grant_l, grant_s, grant_w, grant_e, grant_n};

  // A selected port keeps its request through the rts-low cycle
  idle_rts_low: assert property (@(posedge clk) disable iff (rst)
    rts |-> state != ARB_IDLE)
    else $error("rts high while the arbiter was idle");

  stall_hold: assert property (@(posedge clk) disable iff (rst)
    rts && !dcts |=> $stable(tx_data))
    else $error("tx_data changed during a stall");

  one_grant: assert property (@(posedge clk) disable iff (rst)
    rts && dcts |-> $onehot(grant_vec))
    else $error("Transfer without exactly one grant high");

  // A granted buffer requested in the cycle before, so it held a flit
  grant_has_flit: assert property (@(posedge clk) disable iff (rst)
    |grant_vec |-> (grant_vec & ~$past(req_vec)) == '0)
    else $error("Grant to a buffer that held no flit");

endmodule

bind output_arbiter router_output_asserts arb_checks (
  .clk(clk), .rst(rst), .dcts(dcts), .rts(rts),
  .req_n(req_n), .req_e(req_e), .req_w(req_w), .req_s(req_s), .req_l(req_l),
  .grant_n(grant_n), .grant_e(grant_e), .grant_w(grant_w),
  .grant_s(grant_s), .grant_l(grant_l),
  .tx_data(tx_data), .state(state)
);

// File: router_output.sv
module router_output (
  input  logic                clk,
  input  logic                rst,
  input  logic                dcts,
  input  logic                wr_n,
  input  logic                wr_e,
  input  logic                wr_w,
  input  logic                wr_s,
  input  logic                wr_l,
  input  noc_flit_pkg::flit_t data_n,
  input  noc_flit_pkg::flit_t data_e,
  input  noc_flit_pkg::flit_t data_w,
  input  noc_flit_pkg::flit_t data_s,
  input  noc_flit_pkg::flit_t data_l,
  output logic                full_n,
  output logic                full_e,
  output logic                full_w,
  output logic                full_s,
  output logic                full_l,
  output logic                rts,
  output noc_flit_pkg::flit_t tx_data
);
  import noc_flit_pkg::*;

  logic  req_n, req_e, req_w, req_s, req_l;
  logic  grant_n, grant_e, grant_w, grant_s, grant_l;
  flit_t head_n, head_e, head_w, head_s, head_l;

  // Input buffers
  flit_fifo buf_n (
    .clk(clk), .rst(rst), .wr(wr_n), .rd(grant_n), .wr_data(data_n),
    .head(head_n), .full(full_n), .req(req_n)
  );

  flit_fifo buf_e (
    .clk(clk), .rst(rst), .wr(wr_e), .rd(grant_e), .wr_data(data_e),
    .head(head_e), .full(full_e), .req(req_e)
  );

  flit_fifo buf_w (
    .clk(clk), .rst(rst), .wr(wr_w), .rd(grant_w), .wr_data(data_w),
    .head(head_w), .full(full_w), .req(req_w)
  );

  flit_fifo buf_s (
    .clk(clk), .rst(rst), .wr(wr_s), .rd(grant_s), .wr_data(data_s),
    .head(head_s), .full(full_s), .req(req_s)
  );

  flit_fifo buf_l (
    .clk(clk), .rst(rst), .wr(wr_l), .rd(grant_l), .wr_data(data_l),
    .head(head_l), .full(full_l), .req(req_l)
  );

  // Arbiter with crossbar, drives the output link
  output_arbiter arb (
    .clk(clk), .rst(rst), .dcts(dcts),
    .req_n(req_n), .req_e(req_e), .req_w(req_w), .req_s(req_s), .req_l(req_l),
    .head_n(head_n), .head_e(head_e), .head_w(head_w),
    .head_s(head_s), .head_l(head_l),
    .grant_n(grant_n), .grant_e(grant_e), .grant_w(grant_w),
    .grant_s(grant_s), .grant_l(grant_l),
    .rts(rts), .tx_data(tx_data)
  );

endmodule

// File: output_arbiter.sv
`include "noc_config.svh"

module output_arbiter (
  input  logic                clk,
  input  logic                rst,
  input  logic                dcts,
  input  logic                req_n,
  input  logic                req_e,
  input  logic                req_w,
  input  logic                req_s,
  input  logic                req_l,
  input  noc_flit_pkg::flit_t head_n,
  input  noc_flit_pkg::flit_t head_e,
  input  noc_flit_pkg::flit_t head_w,
  input  noc_flit_pkg::flit_t head_s,
  input  noc_flit_pkg::flit_t head_l,
  output logic                grant_n,
  output logic                grant_e,
  output logic                grant_w,
  output logic                grant_s,
  output logic                grant_l,
  output logic                rts,
  output noc_flit_pkg::flit_t tx_data
);
  import noc_flit_pkg::*;
  import noc_arb_pkg::*;

  localparam int unsigned NUM_PORTS = `NOC_NUM_PORTS;
  localparam int unsigned LOCAL_IDX = NUM_PORTS - 1;

  arb_state_t  state;
  arb_state_t  next_state;
  port_sel_t   req;
  port_sel_t   sel;
  int unsigned first;
  logic        xfer;
  logic        stall;
  logic        rts_next;

  assign req   = {req_l, req_s, req_w, req_e, req_n};
  assign xfer  = rts && dcts;
  assign stall = rts && !dcts;

  // First high request, searched round from port index start
  function automatic arb_state_t pick(input port_sel_t r, input int unsigned start);
    arb_state_t  res;
    int unsigned idx;
    res = ARB_IDLE;
    for (int k = NUM_PORTS - 1; k >= 0; k--) begin // Walk backwards, earliest wins
      idx = start + k;
      if (idx >= NUM_PORTS)
        idx = idx - NUM_PORTS;
      if (r[idx])
        res = arb_state_t'(idx + 1);
    end
    return res;
  endfunction

  // Each port state checks itself first, idle starts at Local
  always_comb begin
    if (state == ARB_IDLE)
      first = LOCAL_IDX;
    else
      first = int'(state) - 1;
    next_state = pick(req, first);
  end

  // Registered rts, low in idle and for one cycle after every transfer
  assign rts_next = (state != ARB_IDLE) && !xfer;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ARB_IDLE;
      rts   <= 1'b0;
    end else begin
      if (!stall)
        state <= next_state; // Held while the link is stalled
      rts <= rts_next;
    end
  end

  // Crossbar select
  always_comb begin
    unique case (state)
      ARB_NORTH: sel = 5'b00001;
      ARB_EAST:  sel = 5'b00010;
      ARB_WEST:  sel = 5'b00100;
      ARB_SOUTH: sel = 5'b01000;
      ARB_LOCAL: sel = 5'b10000;
      default:   sel = 5'b00000;
    endcase
  end

  // One-hot AND-OR mux, zero in idle
  assign tx_data = ({$bits(flit_t){sel[0]}} & head_n)
                 | ({$bits(flit_t){sel[1]}} & head_e)
                 | ({$bits(flit_t){sel[2]}} & head_w)
                 | ({$bits(flit_t){sel[3]}} & head_s)
                 | ({$bits(flit_t){sel[4]}} & head_l);

  // Pop strobes, high only on a transfer edge
  assign grant_n = sel[0] && xfer;
  assign grant_e = sel[1] && xfer;
  assign grant_w = sel[2] && xfer;
  assign grant_s = sel[3] && xfer;
  assign grant_l = sel[4] && xfer;

endmodule

// File: flit_fifo.sv
`include "noc_config.svh"

module flit_fifo (
  input  logic                clk,
  input  logic                rst,
  input  logic                wr,
  input  logic                rd,
  input  noc_flit_pkg::flit_t wr_data,
  output noc_flit_pkg::flit_t head,
  output logic                full,
  output logic                req
);
  import noc_flit_pkg::*;

  localparam int DEPTH = `NOC_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  flit_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  fifo_count_t      count;
  fifo_count_t      count_next;
  logic             do_wr;
  logic             do_rd;

  // Pointer wrap also covers depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign do_wr = wr && !full; // Dropped when full, even with a pop
  assign do_rd = rd && (count != '0);

  always_comb begin
    count_next = count;
    if (do_wr && !do_rd)
      count_next = count + 1'b1;
    else if (!do_wr && do_rd)
      count_next = count - 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      full   <= 1'b0;
    end else begin
      if (do_wr) wr_ptr <= ptr_inc(wr_ptr);
      if (do_rd) rd_ptr <= ptr_inc(rd_ptr);
      count <= count_next;
      full  <= (count_next == fifo_count_t'(DEPTH));
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= wr_data;
  end

  assign head = mem[rd_ptr];

  // A last flit that is leaving no longer counts as a request
  assign req = (count > fifo_count_t'(1)) || ((count == fifo_count_t'(1)) && !rd);

endmodule

// File: noc_arb_pkg.sv
package noc_arb_pkg;

  // Port states follow the port_sel_t bit order, offset by one
  typedef enum logic [2:0] {
    ARB_IDLE,
    ARB_NORTH,
    ARB_EAST,
    ARB_WEST,
    ARB_SOUTH,
    ARB_LOCAL
  } arb_state_t;

endpackage

// File: noc_flit_pkg.sv
`include "noc_config.svh"

package noc_flit_pkg;

  // Opaque to the RTL
  typedef logic [`NOC_FLIT_WIDTH-1:0] flit_t;

  // One-hot, bit 0 North up to bit 4 Local
  typedef logic [`NOC_NUM_PORTS-1:0] port_sel_t;

  // Occupancy from 0 up to and including the depth
  typedef logic [$clog2(`NOC_FIFO_DEPTH+1)-1:0] fifo_count_t;

endpackage

// File: noc_config.svh
`ifndef NOC_CONFIG_SVH
`define NOC_CONFIG_SVH

// Flit width in bits, source port in the top 3 bits
`define NOC_FLIT_WIDTH 16

// Entries per input buffer
`define NOC_FIFO_DEPTH 4

// North, East, West, South, Local
`define NOC_NUM_PORTS 5

`endif
